/* hdl/ball_cfg.svh */
`ifndef BALL_CFG_SVH
`define BALL_CFG_SVH

// screen coordinate width in bits
`define COORD_W 10

// brick health width, zero is an empty cell
`define HEALTH_W 2

// wall positions, the ball turns back on reaching them
`define FIELD_X_MAX 156
`define FIELD_Y_MAX 116

// ball is a square of this edge length
`define BALL_SIZE 2

// paddle top row and paddle width
`define PLAT_Y 110
`define PLAT_W 16

`endif

/* hdl/ball_geom_pkg.sv */
`include "ball_cfg.svh"

`default_nettype none

package ball_geom_pkg;

	// one screen coordinate, same width for x and y
	typedef logic [`COORD_W-1:0] coord_t;

	// direction of one axis
	// 1 moves toward larger coordinates
	typedef logic dir_t;

endpackage

`default_nettype wire

/* hdl/brick_pkg.sv */
`include "ball_cfg.svh"

`default_nettype none

package brick_pkg;

	// brick health, zero means no brick in the cell
	typedef logic [`HEALTH_W-1:0] health_t;

	// neighbour cell under test
	typedef enum logic [1:0] {
		PROBE_V,
		PROBE_H,
		PROBE_D
	} probe_e;

	// step inside one probe
	// idle outside a running frame and during the update cycle
	typedef enum logic [1:0] {
		STEP_IDLE,
		STEP_LOAD,
		STEP_CHECK,
		STEP_WRITE
	} probe_step_e;

endpackage

`default_nettype wire

/* hdl/ball_direction.sv */
`include "ball_cfg.svh"

`default_nettype none

module ball_direction
	import ball_geom_pkg::*;
(
	input  wire logic clk,
	input  wire logic resetn,
	input  coord_t    ball_x,
	input  coord_t    ball_y,
	input  coord_t    plat_x,
	input  wire logic update,
	input  wire logic hit_v,
	input  wire logic hit_h,
	input  wire logic hit_d,
	output dir_t      x_dir,
	output dir_t      y_dir
);

	// wall positions
	localparam coord_t X_WALL = `FIELD_X_MAX;
	localparam coord_t Y_WALL = `FIELD_Y_MAX;

	// geometry one bit wider so the edge sums never wrap
	localparam logic [`COORD_W:0] BALL_EXT = `BALL_SIZE;
	localparam logic [`COORD_W:0] PLAT_EXT = `PLAT_W;
	localparam logic [`COORD_W:0] PLAT_ROW = `PLAT_Y;

	logic [`COORD_W:0] ball_bottom;
	logic [`COORD_W:0] ball_right;
	logic [`COORD_W:0] plat_right;
	logic              plat_touch;

	assign ball_bottom = {1'b0, ball_y} + BALL_EXT;
	assign ball_right  = {1'b0, ball_x} + BALL_EXT;
	assign plat_right  = {1'b0, plat_x} + PLAT_EXT;

	// lower edge on the paddle row and some x overlap with the paddle
	assign plat_touch = (ball_bottom == PLAT_ROW)
		&& (ball_right > {1'b0, plat_x})
		&& ({1'b0, ball_x} < plat_right);

	always_ff @(posedge clk) begin
		if (!resetn) begin
			x_dir <= 1'b0;
			y_dir <= 1'b0;
		end else begin
			// walls win over brick hits
			if (ball_x == X_WALL) begin
				x_dir <= 1'b0;
			end else if (ball_x == '0) begin
				x_dir <= 1'b1;
			end else if (update && (hit_h || hit_d)) begin
				x_dir <= ~x_dir;
			end

			// paddle sends the ball up, ahead of any brick flip
			if (ball_y == Y_WALL) begin
				y_dir <= 1'b0;
			end else if (ball_y == '0) begin
				y_dir <= 1'b1;
			end else if (plat_touch) begin
				y_dir <= 1'b0;
			end else if (update && (hit_v || hit_d)) begin
				y_dir <= ~y_dir;
			end
		end
	end

endmodule

`default_nettype wire

/* hdl/probe_sequencer.sv */
`include "ball_cfg.svh"

`default_nettype none

module probe_sequencer
	import brick_pkg::*;
(
	input  wire logic  clk,
	input  wire logic  resetn,
	input  wire logic  go,
	input  wire logic  hit_v,
	input  wire logic  hit_h,
	output probe_e      probe,
	output probe_step_e step,
	output logic        update
);

	typedef enum logic [1:0] {
		S_IDLE,
		S_RUN,
		S_UPDATE
	} state_e;

	state_e      state_q;
	state_e      state_d;
	probe_step_e step_q;
	probe_step_e step_d;
	probe_e      probe_q;
	probe_e      probe_d;

	always_comb begin
		state_d = state_q;
		step_d  = step_q;
		probe_d = probe_q;
		case (state_q)
			S_IDLE: begin
				// go only counts here and is ignored while busy
				if (go) begin
					state_d = S_RUN;
					step_d  = STEP_LOAD;
					probe_d = PROBE_V;
				end
			end
			S_RUN: begin
				case (step_q)
					STEP_LOAD:  step_d = STEP_CHECK;
					STEP_CHECK: step_d = STEP_WRITE;
					default: begin
						// write finished so pick the next probe
						step_d = STEP_LOAD;
						case (probe_q)
							PROBE_V: probe_d = PROBE_H;
							PROBE_H: begin
								// diagonal only when both edges were clear
								if (hit_v || hit_h) begin
									state_d = S_UPDATE;
								end else begin
									probe_d = PROBE_D;
								end
							end
							default: state_d = S_UPDATE;
						endcase
					end
				endcase
			end
			default: state_d = S_IDLE;
		endcase
	end

	always_ff @(posedge clk) begin
		if (!resetn) begin
			state_q <= S_IDLE;
			step_q  <= STEP_LOAD;
			probe_q <= PROBE_V;
		end else begin
			state_q <= state_d;
			step_q  <= step_d;
			probe_q <= probe_d;
		end
	end

	// step reads idle outside the running state
	assign step   = (state_q == S_RUN) ? step_q : STEP_IDLE;
	assign probe  = probe_q;
	assign update = (state_q == S_UPDATE);

	// update comes right after the last write of a frame
	a_update_after_write: assert property (@(posedge clk) disable iff (!resetn)
		update |-> ($past(step) == STEP_WRITE));

endmodule

`default_nettype wire

/* hdl/brick_probe_datapath.sv */
`include "ball_cfg.svh"

`default_nettype none

module brick_probe_datapath
	import ball_geom_pkg::*;
	import brick_pkg::*;
(
	input  wire logic  clk,
	input  wire logic  resetn,
	input  probe_e      probe,
	input  probe_step_e step,
	input  coord_t      ball_x,
	input  coord_t      ball_y,
	input  dir_t        x_dir,
	input  dir_t        y_dir,
	input  health_t     mem_health,
	output coord_t      mem_x,
	output coord_t      mem_y,
	output logic        mem_write,
	output health_t     mem_wdata,
	output logic        hit_v,
	output logic        hit_h,
	output logic        hit_d
);

	coord_t x_step;
	coord_t y_step;
	logic   brick_here;
	logic   probe_hit;

	// one cell ahead along each axis
	assign x_step = x_dir ? (ball_x + coord_t'(1)) : (ball_x - coord_t'(1));
	assign y_step = y_dir ? (ball_y + coord_t'(1)) : (ball_y - coord_t'(1));

	assign brick_here = (mem_health != '0);

	always_ff @(posedge clk) begin
		if (!resetn) begin
			mem_x <= '0;
			mem_y <= '0;
			hit_v <= 1'b0;
			hit_h <= 1'b0;
			hit_d <= 1'b0;
		end else begin
			case (step)
				STEP_LOAD: begin
					case (probe)
						PROBE_V: begin
							mem_x <= ball_x;
							mem_y <= y_step;
							// first probe of the frame starts clean
							hit_v <= 1'b0;
							hit_h <= 1'b0;
							hit_d <= 1'b0;
						end
						PROBE_H: begin
							mem_x <= x_step;
							mem_y <= ball_y;
						end
						default: begin
							mem_x <= x_step;
							mem_y <= y_step;
						end
					endcase
				end
				STEP_CHECK: begin
					// health for the loaded address is valid in this cycle
					if (brick_here) begin
						case (probe)
							PROBE_V: hit_v <= 1'b1;
							PROBE_H: hit_h <= 1'b1;
							default: hit_d <= 1'b1;
						endcase
					end
				end
				default: ;
			endcase
		end
	end

	// weakened brick, written back on the write step
	always_ff @(posedge clk) begin
		if ((step == STEP_CHECK) && brick_here) begin
			mem_wdata <= mem_health - health_t'(1);
		end
	end

	// flag of the probe now writing
	always_comb begin
		case (probe)
			PROBE_V: probe_hit = hit_v;
			PROBE_H: probe_hit = hit_h;
			default: probe_hit = hit_d;
		endcase
	end

	// address still holds the probed cell during write
	assign mem_write = (step == STEP_WRITE) && probe_hit;

	// a write follows its check, and a hit brick never comes back at full health
	a_write_data: assert property (@(posedge clk) disable iff (!resetn)
		mem_write |-> ($past(step) == STEP_CHECK) && (mem_wdata != '1));

endmodule

`default_nettype wire

/* hdl/ball_logic.sv */
`include "ball_cfg.svh"

`default_nettype none

module ball_logic
	import ball_geom_pkg::*;
	import brick_pkg::*;
(
	input  wire logic clk,
	input  wire logic resetn,
	input  wire logic go,
	input  coord_t    ball_x,
	input  coord_t    ball_y,
	input  coord_t    plat_x,
	input  health_t   mem_health,
	output coord_t    mem_x,
	output coord_t    mem_y,
	output logic      mem_write,
	output health_t   mem_wdata,
	output dir_t      x_dir,
	output dir_t      y_dir,
	output logic      done
);

	probe_e      probe;
	probe_step_e step;
	logic        hit_v;
	logic        hit_h;
	logic        hit_d;

	// done is the update strobe of the sequencer
	probe_sequencer seq0 (
		.clk    (clk),
		.resetn (resetn),
		.go     (go),
		.hit_v  (hit_v),
		.hit_h  (hit_h),
		.probe  (probe),
		.step   (step),
		.update (done)
	);

	brick_probe_datapath dp0 (
		.clk        (clk),
		.resetn     (resetn),
		.probe      (probe),
		.step       (step),
		.ball_x     (ball_x),
		.ball_y     (ball_y),
		.x_dir      (x_dir),
		.y_dir      (y_dir),
		.mem_health (mem_health),
		.mem_x      (mem_x),
		.mem_y      (mem_y),
		.mem_write  (mem_write),
		.mem_wdata  (mem_wdata),
		.hit_v      (hit_v),
		.hit_h      (hit_h),
		.hit_d      (hit_d)
	);

	// directions flip on the cycle after done
	ball_direction dir0 (
		.clk    (clk),
		.resetn (resetn),
		.ball_x (ball_x),
		.ball_y (ball_y),
		.plat_x (plat_x),
		.update (done),
		.hit_v  (hit_v),
		.hit_h  (hit_h),
		.hit_d  (hit_d),
		.x_dir  (x_dir),
		.y_dir  (y_dir)
	);

endmodule

`default_nettype wire

/* verif/tb_ball_logic.sv */
`include "ball_cfg.svh"

`default_nettype none

module tb_ball_logic
	import ball_geom_pkg::*;
	import brick_pkg::*;
();

	localparam int     FRAME_TIMEOUT = 40;
	localparam coord_t PAD_ROW_Y     = `PLAT_Y - `BALL_SIZE;

	// one write seen on the memory port
	typedef struct packed {
		coord_t  x;
		coord_t  y;
		health_t data;
	} wr_t;

	logic    clk;
	logic    resetn;
	logic    go;
	logic    mem_write;
	logic    done;
	coord_t  ball_x;
	coord_t  ball_y;
	coord_t  plat_x;
	coord_t  mem_x;
	coord_t  mem_y;
	health_t mem_health;
	health_t mem_wdata;
	dir_t    x_dir;
	dir_t    y_dir;

	// sparse brick map keyed by {x, y}
	health_t cells[int];
	wr_t     wr_seen[$];
	wr_t     wr_exp[$];
	integer  seed;
	int      errors;
	int      errors_at_start;
	int      tests_run;
	int      tests_failed;
	string   test_name;
	bit      timed_out;

	ball_logic dut0 (.*);

	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	function automatic int cell_key(input coord_t x, input coord_t y);
		return int'({x, y});
	endfunction

	function automatic int rand_below(input int n);
		return $unsigned($random(seed)) % n;
	endfunction

	// about half the cells hold a brick
	function automatic health_t rand_health();
		return rand_below(2) ? health_t'(1 + rand_below(3)) : '0;
	endfunction

	// read data for the loaded address is ready before the check edge
	always @(negedge clk) begin
		mem_health <= cells.exists(cell_key(mem_x, mem_y)) ? cells[cell_key(mem_x, mem_y)] : '0;
	end

	// writes land in the map and in the log of the frame
	always @(posedge clk) begin
		if (resetn && mem_write) begin
			cells[cell_key(mem_x, mem_y)] = mem_wdata;
			wr_seen.push_back({mem_x, mem_y, mem_wdata});
		end
	end

	task automatic check(input string what, input logic [31:0] expected,
			input logic [31:0] actual);
		if (expected !== actual) begin
			errors++;
			$display("Mismatch in %s, %s: expected %0d, actual %0d", test_name, what,
				expected, actual);
		end
	endtask

	task automatic begin_test(input string name);
		test_name = name;
		errors_at_start = errors;
		tests_run++;
	endtask

	task automatic end_test();
		if (errors == errors_at_start) begin
			$display("%s: ok", test_name);
		end else begin
			tests_failed++;
			$display("%s: %0d errors", test_name, errors - errors_at_start);
		end
	endtask

	task automatic drive_ball(input coord_t x, input coord_t y);
		@(posedge clk);
		ball_x <= x;
		ball_y <= y;
	endtask

	// dut takes the position on the next edge and is read back mid cycle
	task automatic settle();
		@(posedge clk);
		@(negedge clk);
	endtask

	// one frame against the reference model of the probe rules
	task automatic run_frame(input coord_t bx, input coord_t by, input dir_t xd, input dir_t yd,
			input health_t v_hp, input health_t h_hp, input health_t d_hp, input int busy_at);
		coord_t nx;
		coord_t ny;
		logic   hv;
		logic   hh;
		logic   hd;
		logic   extra;
		int     n;
		if (timed_out) begin
			return;
		end
		// neighbour cells one step ahead of the ball
		nx = xd ? bx + coord_t'(1) : bx - coord_t'(1);
		ny = yd ? by + coord_t'(1) : by - coord_t'(1);
		cells.delete();
		cells[cell_key(bx, ny)] = v_hp;
		cells[cell_key(nx, by)] = h_hp;
		cells[cell_key(nx, ny)] = d_hp;
		hv = (v_hp != '0);
		hh = (h_hp != '0);
		// diagonal read only when both edge cells are empty
		hd = !hv && !hh && (d_hp != '0);
		wr_exp.delete();
		if (hv) begin
			wr_exp.push_back({bx, ny, health_t'(v_hp - 1)});
		end
		if (hh) begin
			wr_exp.push_back({nx, by, health_t'(h_hp - 1)});
		end
		if (hd) begin
			wr_exp.push_back({nx, ny, health_t'(d_hp - 1)});
		end
		// walls give the start directions before the ball moves into the field
		drive_ball(xd ? coord_t'(0) : coord_t'(`FIELD_X_MAX),
			yd ? coord_t'(0) : coord_t'(`FIELD_Y_MAX));
		drive_ball(bx, by);
		wr_seen.delete();
		@(posedge clk);
		go <= 1'b1;
		n = 0;
		while (!done && n < FRAME_TIMEOUT) begin
			@(posedge clk);
			n++;
			// single go pulse while busy if asked for
			go <= (n == busy_at);
		end
		if (!done) begin
			$display("Error in %s: done did not come within %0d cycles of go", test_name,
				FRAME_TIMEOUT);
			errors++;
			timed_out = 1'b1;
			return;
		end
		check("done latency", (hv || hh) ? 7 : 10, n - 1);
		// directions flip on the edge that ends done
		@(negedge clk);
		check("x_dir", xd ^ (hh | hd), x_dir);
		check("y_dir", yd ^ (hv | hd), y_dir);
		check("write count", wr_exp.size(), wr_seen.size());
		foreach (wr_exp[i]) begin
			if (i < wr_seen.size()) begin
				check("write x", wr_exp[i].x, wr_seen[i].x);
				check("write y", wr_exp[i].y, wr_seen[i].y);
				check("write data", wr_exp[i].data, wr_seen[i].data);
			end
		end
		// the busy go was dropped so the dut stays quiet
		extra = 1'b0;
		repeat (12) begin
			@(posedge clk);
			extra = extra | done | mem_write;
		end
		check("activity after done", 0, extra);
	endtask

	initial begin
		coord_t ry;
		seed = 33618;
		errors = 0;
		tests_run = 0;
		tests_failed = 0;
		timed_out = 1'b0;
		resetn = 1'b0;
		go = 1'b0;
		ball_x = coord_t'(80);
		ball_y = coord_t'(40);
		plat_x = coord_t'(50);
		mem_health = '0;
		repeat (16) @(posedge clk);
		resetn <= 1'b1;

		begin_test("wall_rebound");
		drive_ball(coord_t'(0), coord_t'(0));
		settle();
		check("x_dir at left wall", 1, x_dir);
		check("y_dir at top wall", 1, y_dir);
		drive_ball(coord_t'(`FIELD_X_MAX), coord_t'(`FIELD_Y_MAX));
		settle();
		check("x_dir at right wall", 0, x_dir);
		check("y_dir at bottom wall", 0, y_dir);
		end_test();

		// paddle spans x 50 to 66
		begin_test("paddle_rebound");
		drive_ball(coord_t'(100), coord_t'(0));
		settle();
		drive_ball(coord_t'(100), PAD_ROW_Y);
		settle();
		check("y_dir beside paddle", 1, y_dir);
		drive_ball(coord_t'(55), PAD_ROW_Y);
		settle();
		check("y_dir on paddle", 0, y_dir);
		end_test();

		begin_test("empty_frame");
		run_frame(coord_t'(80), coord_t'(40), 1'b1, 1'b0, 2'd0, 2'd0, 2'd0, 0);
		end_test();
		begin_test("vertical_hit");
		run_frame(coord_t'(30), coord_t'(60), 1'b0, 1'b1, 2'd3, 2'd0, 2'd0, 0);
		end_test();
		begin_test("horizontal_hit");
		run_frame(coord_t'(120), coord_t'(20), 1'b1, 1'b1, 2'd0, 2'd2, 2'd0, 0);
		end_test();
		begin_test("diagonal_hit");
		run_frame(coord_t'(64), coord_t'(90), 1'b0, 1'b0, 2'd0, 2'd0, 2'd1, 0);
		end_test();

		// interior positions only and never on the paddle row
		begin_test("random_frames");
		for (int f = 0; f < 40; f++) begin
			ry = coord_t'(1 + rand_below(`FIELD_Y_MAX - 1));
			if (ry == PAD_ROW_Y) begin
				ry++;
			end
			run_frame(coord_t'(1 + rand_below(`FIELD_X_MAX - 1)), ry, dir_t'(rand_below(2)),
				dir_t'(rand_below(2)), rand_health(), rand_health(), rand_health(),
				2 + rand_below(4));
		end
		end_test();

		$display("tests run %0d, tests failed %0d, errors %0d", tests_run, tests_failed, errors);
		if (errors == 0) begin
			$display("Simulation passed");
		end else begin
			$display("Simulation failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

/* ball_logic.f */
+incdir+hdl
hdl/ball_geom_pkg.sv
hdl/brick_pkg.sv
hdl/ball_direction.sv
hdl/probe_sequencer.sv
hdl/brick_probe_datapath.sv
hdl/ball_logic.sv
verif/tb_ball_logic.sv
